// ==== verilog.f ====
+incdir+design
design/crPkg.sv
design/crStatusIf.sv
design/crWbPipe.sv
design/crFile.sv
design/trapUnit.sv
design/crSubsystem.sv
bench/crSubsystem_props.sv
bench/crSubsystemTb.sv

// ==== bench/crSubsystemTb.sv ====
// self-checking testbench for the control-register subsystem; compile with verilog.f and run as top
`timescale 1ns/100ps
`include "cr_params.svh"

module crSubsystemTb import crPkg::*; ();

	logic clock;
	logic rstN;
	logic hold;
	logic wbValid;
	crId wbId;
	crValue wbValue;
	logic flushEx1;
	logic flushEx2;
	logic flushEx3;
	crAddr pc;
	crId readId;
	crValue readValue;
	logic trapReq;
	logic [15:0] trapCause;
	crValue trapAddr;
	logic rteReq;
	logic redirectValid;
	crAddr redirectPc;
	crValue lrOut;
	crValue gbrOut;
	crValue vbrOut;
	crValue srOut;

	// reference model state
	crValue refRegs [0:63];
	// index 0 is EX2 and 2 is EX4
	crWbEntry stageQ [$];
	logic expRedirect;
	crAddr expRedirectPc;
	int failCount;

	crSubsystem #(.enableMmu(1'b1)) i_dut (.*);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic stopOnError(input string msg);
		failCount++;
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic checkValue(input crValue got, input crValue exp, input string what);
		if (got !== exp)
			stopOnError($sformatf("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkRedirect(input logic gotValid, input crAddr gotPc,
		input logic expValid, input crAddr expPc);
		if (gotValid !== expValid)
			stopOnError($sformatf("[ERROR] %0d ns: redirectValid is %b, expected %b",
				$time, gotValid, expValid));
		else if (expValid && gotPc !== expPc)
			stopOnError($sformatf("[ERROR] %0d ns: redirectPc is %h, expected %h",
				$time, gotPc, expPc));
	endtask

	// failed concurrent assertions in both bound checkers
	function automatic int assertionFailures();
		return i_dut.i_file.i_fileAsserts.errorCount + i_dut.i_trap.i_trapAsserts.errorCount;
	endfunction

	// expected read port value
	function automatic crValue expectedRead(input crId id);
		case (id)
			CR_PC: return crValue'(pc);
			CR_SR, CR_EXSR, CR_LR, CR_VBR, CR_SPC, CR_SSP, CR_GBR, CR_TBR, CR_TEA,
			CR_TTB, CR_MMCR, CR_KRR: return refRegs[id];
			// ZZR, IMM and unused codes
			default: return '0;
		endcase
	endfunction

	// commit into the model
	// GBR and VBR keep the upper half as FPSR and VBRCM, so the whole word stays
	function automatic void commitToModel(input crWbEntry e);
		if (e.valid)
		begin
			case (e.id)
				CR_SPC, CR_SSP, CR_TBR: refRegs[e.id] = crValue'(e.value[`CR_ADDR_W-1:0]);
				CR_SR, CR_EXSR, CR_LR, CR_VBR, CR_GBR, CR_TEA, CR_TTB, CR_MMCR, CR_KRR:
					refRegs[e.id] = e.value;
				default: ;
			endcase
		end
	endfunction

	function automatic logic pipeBusy();
		return stageQ[0].valid || stageQ[1].valid || stageQ[2].valid;
	endfunction

	// mostly named registers
	// now and then any code
	function automatic crId pickId();
		if ($urandom_range(0, 3) == 0)
			return crId'($urandom_range(0, 63));
		return crId'($urandom_range(0, 13));
	endfunction

	// model step at each rising edge
	// inputs settled one ns after the previous edge
	always @(posedge clock)
	begin : modelUpdate
		crWbEntry entry;
		crValue oldSr;
		crValue oldExsr;
		crValue oldVbr;
		crValue oldSpc;
		if (rstN && !hold)
		begin
			oldSr = refRegs[CR_SR];
			oldExsr = refRegs[CR_EXSR];
			oldVbr = refRegs[CR_VBR];
			oldSpc = refRegs[CR_SPC];
			expRedirect = trapReq || rteReq;
			// trap beats return
			if (trapReq)
			begin
				refRegs[CR_EXSR] = {16'h0000, trapCause, oldSr[31:0]};
				refRegs[CR_SPC] = crValue'(pc);
				refRegs[CR_TEA] = trapAddr;
				refRegs[CR_SR] = oldSr | (64'd1 << `CR_SR_MD) | (64'd1 << `CR_SR_BL);
				expRedirectPc = oldVbr[`CR_ADDR_W-1:0] + crAddr'(trapCause[7:0]) * 8;
			end
			else if (rteReq)
			begin
				refRegs[CR_SR] = {oldSr[63:32], oldExsr[31:0]};
				expRedirectPc = oldSpc[`CR_ADDR_W-1:0];
			end
			// EX4 write lands after the trap, so it wins
			commitToModel(stageQ[2]);
			entry = stageQ[1];
			entry.valid = entry.valid && !flushEx3;
			stageQ[1] = entry;
			entry = stageQ[0];
			entry.valid = entry.valid && !flushEx2;
			stageQ[0] = entry;
			void'(stageQ.pop_back());
			entry.valid = wbValid && !flushEx1;
			entry.id = wbId;
			entry.value = wbValue;
			stageQ.push_front(entry);
		end
		else if (rstN)
			expRedirect = 1'b0;
	end

	// compare at the falling edge
	always @(negedge clock)
	begin
		if (assertionFailures() != 0)
			stopOnError("a concurrent assertion on the register file or trap unit failed");
		if (rstN)
		begin
			checkValue(readValue, expectedRead(readId), $sformatf("readValue of id %0h", readId));
			checkValue(srOut, refRegs[CR_SR], "srOut");
			checkValue(lrOut, refRegs[CR_LR], "lrOut");
			checkValue(gbrOut, refRegs[CR_GBR], "gbrOut");
			checkValue(vbrOut, refRegs[CR_VBR], "vbrOut");
			checkRedirect(redirectValid, redirectPc, expRedirect, expRedirectPc);
		end
	end

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	task automatic driveIdle();
		hold = 1'b0;
		wbValid = 1'b0;
		wbId = CR_ZZR;
		wbValue = '0;
		flushEx1 = 1'b0;
		flushEx2 = 1'b0;
		flushEx3 = 1'b0;
		pc = '0;
		readId = CR_ZZR;
		trapReq = 1'b0;
		trapCause = '0;
		trapAddr = '0;
		rteReq = 1'b0;
	endtask

	task automatic randomInputs();
		hold = ($urandom_range(0, 4) == 0);
		wbValid = ($urandom_range(0, 1) == 1);
		wbId = pickId();
		wbValue = {$urandom, $urandom};
		flushEx1 = ($urandom_range(0, 7) == 0);
		flushEx2 = ($urandom_range(0, 7) == 0);
		flushEx3 = ($urandom_range(0, 7) == 0);
		pc = crAddr'({$urandom, $urandom});
		readId = pickId();
		trapCause = 16'($urandom);
		trapAddr = {$urandom, $urandom};
		// never two requests in a row
		// keeps one redirect at a time
		if (trapReq || rteReq)
		begin
			trapReq = 1'b0;
			rteReq = 1'b0;
		end
		else
		begin
			trapReq = ($urandom_range(0, 15) == 0);
			rteReq = ($urandom_range(0, 15) == 0);
		end
	endtask

	task automatic waitDrain();
		int cycles;
		cycles = 0;
		while (pipeBusy() && cycles < 20)
		begin
			step();
			cycles++;
		end
		if (pipeBusy())
			stopOnError("writeback pipeline still busy after 20 cycles");
	endtask

	task automatic waitRedirect();
		int cycles;
		cycles = 0;
		while (redirectValid !== 1'b1 && cycles < 10)
		begin
			@(negedge clock);
			cycles++;
		end
		if (redirectValid !== 1'b1)
			stopOnError("no redirect within 10 cycles of a trap or return request");
	endtask

	initial
	begin
		void'($urandom(88592));
		failCount = 0;
		rstN = 1'b0;
		driveIdle();
		for (int i = 0; i < 64; i++)
			refRegs[i] = '0;
		refRegs[CR_SR] = `CR_SR_RESET;
		stageQ = {crWbEntry'(0), crWbEntry'(0), crWbEntry'(0)};
		expRedirect = 1'b0;
		expRedirectPc = '0;
		repeat (5) @(posedge clock);
		#1;
		rstN = 1'b1;

		// reset value of every code
		for (int i = 0; i < 64; i++)
		begin
			readId = crId'(i);
			step();
		end

		// random writes, holds, flushes, traps and returns
		repeat (800)
		begin
			randomInputs();
			step();
		end
		driveIdle();
		waitDrain();

		// trap vectors off VBR
		// companion half must stay out of the target
		wbValid = 1'b1;
		wbId = CR_VBR;
		wbValue = 64'hBEEF_0000_0010_0000;
		step();
		wbValid = 1'b0;
		waitDrain();
		trapCause = 16'h0A25;
		trapAddr = 64'h0123_4567_89AB_CDEF;
		pc = 48'h0000_8000_1000;
		trapReq = 1'b1;
		step();
		trapReq = 1'b0;
		waitRedirect();
		checkRedirect(redirectValid, redirectPc, 1'b1, 48'h0000_0010_0128);
		step();
		readId = CR_EXSR;
		step();
		readId = CR_SPC;
		step();
		readId = CR_TEA;
		step();

		// return goes back to SPC
		rteReq = 1'b1;
		readId = CR_SR;
		step();
		rteReq = 1'b0;
		waitRedirect();
		checkRedirect(redirectValid, redirectPc, 1'b1, 48'h0000_8000_1000);
		step();

		// SR write commits on the trap edge
		wbValid = 1'b1;
		wbId = CR_SR;
		wbValue = 64'h0000_0000_0000_0001;
		step();
		wbValid = 1'b0;
		step();
		step();
		trapReq = 1'b1;
		step();
		trapReq = 1'b0;
		checkValue(readValue, 64'h0000_0000_0000_0001, "SR after a write on a trap edge");
		waitRedirect();
		step();
		driveIdle();
		waitDrain();

		if (failCount == 0 && assertionFailures() == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== bench/crSubsystem_props.sv ====
// concurrent assertions on the register file and the trap unit, bound in from the bench
`timescale 1ns/100ps
`include "cr_params.svh"

module crAssertions import crPkg::*;
#(
	// 1 when bound into the file, 0 into the trap unit
	parameter bit onFile = 1'b1
)
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic redirectValid,
	input crId readId,
	input crValue readValue,
	input crValue sr,
	input crValue exsr
);

	// failed assertions so far
	int errorCount = 0;

	// first edge out of reset still sees the reset SR
	srAfterReset: assert property (@(posedge clock) $rose(rstN) |-> sr == `CR_SR_RESET)
	else
	begin
		errorCount++;
		$error("SR not at its reset value after reset");
	end

	// nothing moves across a held edge
	holdKeeps: assert property (@(posedge clock) disable iff (!rstN)
		hold |=> $stable(sr) && $stable(exsr))
	else
	begin
		errorCount++;
		$error("SR or EXSR changed across a held edge");
	end

	generate
		if (onFile)
		begin : fileSide
			zzrReadsZero: assert property (@(posedge clock) disable iff (!rstN)
				readId == CR_ZZR |-> readValue == '0)
			else
			begin
				errorCount++;
				$error("ZZR read returned a nonzero value");
			end
		end
		else
		begin : trapSide
			// one-cycle strobe
			redirectOneCycle: assert property (@(posedge clock) disable iff (!rstN)
				redirectValid |=> !redirectValid)
			else
			begin
				errorCount++;
				$error("redirectValid high for two cycles in a row");
			end
		end
	endgenerate

endmodule

bind crFile crAssertions #(.onFile(1'b1)) i_fileAsserts
(
	.clock(clock),
	.rstN(rstN),
	.hold(hold),
	.redirectValid(1'b0),
	.readId(readId),
	.readValue(readValue),
	.sr(sr),
	.exsr(exsr)
);

bind trapUnit crAssertions #(.onFile(1'b0)) i_trapAsserts
(
	.clock(clock),
	.rstN(rstN),
	.hold(hold),
	.redirectValid(redirectValid),
	.readId(CR_ZZR),
	.readValue('0),
	.sr(status.srOut),
	.exsr(status.exsrOut)
);

// ==== design/crSubsystem.sv ====
// control-register subsystem top: writeback pipe, register file and trap unit behind plain ports
`timescale 1ns/100ps

module crSubsystem import crPkg::*;
#(
	// 0 drops the MMU registers
	parameter bit enableMmu = 1'b1
)
(
	input logic clock,
	input logic rstN,
	input logic hold,
	// EX1 register write
	input logic wbValid,
	input crId wbId,
	input crValue wbValue,
	// stage flushes
	input logic flushEx1,
	input logic flushEx2,
	input logic flushEx3,
	// live PC
	input crAddr pc,
	// read port
	input crId readId,
	output crValue readValue,
	// trap and return requests
	input logic trapReq,
	input logic [15:0] trapCause,
	input crValue trapAddr,
	input logic rteReq,
	// fetch redirect
	output logic redirectValid,
	output crAddr redirectPc,
	// architectural registers
	output crValue lrOut,
	output crValue gbrOut,
	output crValue vbrOut,
	output crValue srOut
);

	// EX4 write into the file
	crWbEntry commitEntry;

	// trap unit to file
	crStatusIf statusBus();

	crWbPipe i_wbPipe
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.wbValid(wbValid),
		.wbId(wbId),
		.wbValue(wbValue),
		.flushEx1(flushEx1),
		.flushEx2(flushEx2),
		.flushEx3(flushEx3),
		.commitEntry(commitEntry)
	);

	crFile #(.enableMmu(enableMmu)) i_file
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.commitEntry(commitEntry),
		.pc(pc),
		.readId(readId),
		.readValue(readValue),
		.status(statusBus.file),
		.lrOut(lrOut),
		.gbrOut(gbrOut),
		.vbrOut(vbrOut)
	);

	trapUnit i_trap
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.trapReq(trapReq),
		.trapCause(trapCause),
		.trapAddr(trapAddr),
		.rteReq(rteReq),
		.pc(pc),
		.status(statusBus.trap),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc)
	);

	// SR comes out over the status lines
	assign srOut = statusBus.srOut;

endmodule

// ==== design/trapUnit.sv ====
// trap entry and return-from-exception sequencing with the one-cycle PC redirect
`timescale 1ns/100ps
`include "cr_params.svh"

module trapUnit import crPkg::*;
(
	input logic clock,
	input logic rstN,
	input logic hold,
	// trap request with cause and fault address
	input logic trapReq,
	input logic [15:0] trapCause,
	input crValue trapAddr,
	// return from exception
	input logic rteReq,
	// PC of the trapping instruction
	input crAddr pc,
	// status, save and vector lines to the file
	crStatusIf.trap status,
	// redirect to fetch
	output logic redirectValid,
	output crAddr redirectPc
);

	// accepted events, nothing is taken on a held edge
	logic takeTrap;
	logic takeRte;
	// vector offset, eight bytes per cause
	crAddr vecOffset;
	// next fetch address
	crAddr target;

	// trap has priority over return
	assign takeTrap = trapReq && !hold;
	assign takeRte = rteReq && !hold && !trapReq;
	assign vecOffset = crAddr'({trapCause[7:0], 3'b000});

	// next values for the trap-owned registers
	always_comb
	begin
		status.srIn = status.srOut;
		status.exsrIn = status.exsrOut;
		status.spcIn = status.spcOut;
		status.teaIn = status.teaOut;
		target = status.spcOut;
		if (takeTrap)
		begin
			// save old SR low word with the cause above it
			status.exsrIn = {16'h0000, trapCause, status.srOut[31:0]};
			status.spcIn = pc;
			status.teaIn = trapAddr;
			// enter supervisor mode with interrupts blocked
			status.srIn[`CR_SR_MD] = 1'b1;
			status.srIn[`CR_SR_BL] = 1'b1;
			target = status.vbrOut + vecOffset;
		end
		else if (takeRte)
		begin
			// restore SR low word, upper word untouched
			status.srIn = {status.srOut[63:32], status.exsrOut[31:0]};
			target = status.spcOut;
		end
	end

	// redirect strobe lasts one cycle
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			redirectValid <= 1'b0;
		else
			redirectValid <= takeTrap || takeRte;
	end

	// target only matters while the strobe is high
	always_ff @(posedge clock)
	begin
		if (takeTrap || takeRte)
			redirectPc <= target;
	end

endmodule

// ==== design/crFile.sv ====
// control-register file with its combinational read port and the EX4 write commit
`timescale 1ns/100ps
`include "cr_params.svh"

module crFile import crPkg::*;
#(
	// 0 leaves TTB, MMCR and KRR tied to zero
	parameter bit enableMmu = 1'b1
)
(
	input logic clock,
	input logic rstN,
	input logic hold,
	// write leaving EX4
	input crWbEntry commitEntry,
	// live PC from fetch
	input crAddr pc,
	// read port
	input crId readId,
	output crValue readValue,
	// status, save and vector lines to the trap unit
	crStatusIf.file status,
	// architectural outputs
	output crValue lrOut,
	output crValue gbrOut,
	output crValue vbrOut
);

	// register storage
	crValue sr;
	crValue exsr;
	crAddr spc;
	crAddr ssp;
	crValue tea;
	crAddr vbr;
	logic [`CR_DATA_W-`CR_ADDR_W-1:0] vbrCm;
	crAddr gbr;
	logic [`CR_DATA_W-`CR_ADDR_W-1:0] fpsr;
	crAddr tbr;
	crValue lr;
	crValue ttb;
	crValue mmcr;
	crValue krr;

	// per-register write enables
	logic wrSr;
	logic wrExsr;
	logic wrSpc;
	logic wrSsp;
	logic wrTea;
	logic wrVbr;
	logic wrGbr;
	logic wrTbr;
	logic wrLr;
	logic wrTtb;
	logic wrMmcr;
	logic wrKrr;

	// decode the committing write
	// ZZR, IMM, PC and unknown codes enable nothing
	always_comb
	begin
		wrSr = 1'b0;
		wrExsr = 1'b0;
		wrSpc = 1'b0;
		wrSsp = 1'b0;
		wrTea = 1'b0;
		wrVbr = 1'b0;
		wrGbr = 1'b0;
		wrTbr = 1'b0;
		wrLr = 1'b0;
		wrTtb = 1'b0;
		wrMmcr = 1'b0;
		wrKrr = 1'b0;
		if (commitEntry.valid)
		begin
			case (commitEntry.id)
				CR_SR: wrSr = 1'b1;
				CR_EXSR: wrExsr = 1'b1;
				CR_SPC: wrSpc = 1'b1;
				CR_SSP: wrSsp = 1'b1;
				CR_TEA: wrTea = 1'b1;
				CR_VBR: wrVbr = 1'b1;
				CR_GBR: wrGbr = 1'b1;
				CR_TBR: wrTbr = 1'b1;
				CR_LR: wrLr = 1'b1;
				CR_TTB: wrTtb = 1'b1;
				CR_MMCR: wrMmcr = 1'b1;
				CR_KRR: wrKrr = 1'b1;
				default: ;
			endcase
		end
	end

	// state update, frozen on hold
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			sr <= `CR_SR_RESET;
			exsr <= '0;
			spc <= '0;
			ssp <= '0;
			tea <= '0;
			vbr <= '0;
			vbrCm <= '0;
			gbr <= '0;
			fpsr <= '0;
			tbr <= '0;
			lr <= '0;
			ttb <= '0;
			mmcr <= '0;
			krr <= '0;
		end
		else if (!hold)
		begin
			// trap-owned registers follow the trap unit
			// a committing write takes priority
			sr <= wrSr ? commitEntry.value : status.srIn;
			exsr <= wrExsr ? commitEntry.value : status.exsrIn;
			spc <= wrSpc ? commitEntry.value[`CR_ADDR_W-1:0] : status.spcIn;
			tea <= wrTea ? commitEntry.value : status.teaIn;

			// software-only registers
			if (wrSsp)
				ssp <= commitEntry.value[`CR_ADDR_W-1:0];
			if (wrTbr)
				tbr <= commitEntry.value[`CR_ADDR_W-1:0];
			if (wrLr)
				lr <= commitEntry.value;

			// upper half goes to the companion register
			if (wrVbr)
			begin
				vbr <= commitEntry.value[`CR_ADDR_W-1:0];
				vbrCm <= commitEntry.value[`CR_DATA_W-1:`CR_ADDR_W];
			end
			if (wrGbr)
			begin
				gbr <= commitEntry.value[`CR_ADDR_W-1:0];
				fpsr <= commitEntry.value[`CR_DATA_W-1:`CR_ADDR_W];
			end

			// MMU block
			if (enableMmu)
			begin
				if (wrTtb)
					ttb <= commitEntry.value;
				if (wrMmcr)
					mmcr <= commitEntry.value;
				if (wrKrr)
					krr <= commitEntry.value;
			end
		end
	end

	// read port
	// narrow registers are zero-extended
	always_comb
	begin
		case (readId)
			CR_PC: readValue = crValue'(pc);
			CR_SR: readValue = sr;
			CR_EXSR: readValue = exsr;
			CR_LR: readValue = lr;
			CR_VBR: readValue = {vbrCm, vbr};
			CR_GBR: readValue = {fpsr, gbr};
			CR_SPC: readValue = crValue'(spc);
			CR_SSP: readValue = crValue'(ssp);
			CR_TBR: readValue = crValue'(tbr);
			CR_TEA: readValue = tea;
			CR_TTB: readValue = enableMmu ? ttb : '0;
			CR_MMCR: readValue = enableMmu ? mmcr : '0;
			CR_KRR: readValue = enableMmu ? krr : '0;
			// ZZR, IMM and unknown codes
			default: readValue = '0;
		endcase
	end

	// outputs
	assign lrOut = lr;
	assign gbrOut = {fpsr, gbr};
	assign vbrOut = {vbrCm, vbr};
	assign status.srOut = sr;
	assign status.exsrOut = exsr;
	assign status.spcOut = spc;
	assign status.teaOut = tea;
	assign status.vbrOut = vbr;

endmodule

// ==== design/crWbPipe.sv ====
// writeback staging for control register writes, from EX1 issue to the EX4 commit
`timescale 1ns/100ps

module crWbPipe import crPkg::*;
(
	input logic clock,
	input logic rstN,
	input logic hold,
	// EX1 write strobe and payload
	input logic wbValid,
	input crId wbId,
	input crValue wbValue,
	// per-stage kills
	input logic flushEx1,
	input logic flushEx2,
	input logic flushEx3,
	// EX4 entry, committed by the file
	output crWbEntry commitEntry
);

	// stage registers
	crWbEntry ex2;
	crWbEntry ex3;
	crWbEntry ex4;

	// whole pipe freezes on hold
	// a flushed stage hands on its entry with valid dropped
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			ex2 <= '0;
			ex3 <= '0;
			ex4 <= '0;
		end
		else if (!hold)
		begin
			// EX1 into EX2
			// flushEx1 stops the capture
			ex2.valid <= wbValid && !flushEx1;
			ex2.id <= wbId;
			ex2.value <= wbValue;

			// EX2 into EX3
			ex3.valid <= ex2.valid && !flushEx2;
			ex3.id <= ex2.id;
			ex3.value <= ex2.value;

			// EX3 into EX4
			ex4.valid <= ex3.valid && !flushEx3;
			ex4.id <= ex3.id;
			ex4.value <= ex3.value;
		end
	end

	// EX4 goes straight to the file
	assign commitEntry = ex4;

endmodule

// ==== design/crStatusIf.sv ====
// status, save and vector register lines between the trap unit and the control-register file
`timescale 1ns/100ps

interface crStatusIf import crPkg::*; ();

	// current register values, from the file
	crValue srOut;
	crValue exsrOut;
	crAddr spcOut;
	crValue teaOut;
	// vector base, low 48 bits only
	crAddr vbrOut;

	// next values, from the trap unit
	// these equal the Out values when no trap or return is in progress
	crValue srIn;
	crValue exsrIn;
	crAddr spcIn;
	crValue teaIn;

	// file side
	// a committing write to one of these overrides its In value
	modport file
	(
		output srOut, exsrOut, spcOut, teaOut, vbrOut,
		input srIn, exsrIn, spcIn, teaIn
	);

	// trap side
	modport trap
	(
		input srOut, exsrOut, spcOut, teaOut, vbrOut,
		output srIn, exsrIn, spcIn, teaIn
	);

endinterface

// ==== design/crPkg.sv ====
// shared types of the control-register block: register IDs, words, addresses, writeback entries
`include "cr_params.svh"

package crPkg;

	// control register select codes
	// codes not listed here read as zero and drop writes
	typedef enum logic [`CR_ID_W-1:0]
	{
		CR_PC = 6'h00,
		CR_LR = 6'h01,
		CR_SR = 6'h02,
		CR_VBR = 6'h03,
		CR_SPC = 6'h04,
		CR_SSP = 6'h05,
		CR_GBR = 6'h06,
		CR_TBR = 6'h07,
		CR_TTB = 6'h08,
		CR_TEA = 6'h09,
		CR_MMCR = 6'h0A,
		CR_EXSR = 6'h0B,
		CR_KRR = 6'h0D,
		// immediate slot, reads zero
		CR_IMM = 6'h1E,
		// zero register
		CR_ZZR = 6'h1F
	} crId;

	// one register word
	typedef logic [`CR_DATA_W-1:0] crValue;

	// one virtual address
	typedef logic [`CR_ADDR_W-1:0] crAddr;

	// one register write on its way from EX1 to EX4
	typedef struct packed
	{
		// cleared by a flush
		logic valid;
		// target register
		crId id;
		// value to write
		crValue value;
	} crWbEntry;

endpackage

// ==== design/cr_params.svh ====
// widths, SR field positions and reset value for the control-register block; include where needed
`ifndef CR_PARAMS_SVH
`define CR_PARAMS_SVH

// full register word
`define CR_DATA_W 64

// virtual address width
// 48-bit registers keep only this many low bits
`define CR_ADDR_W 48

// control register select width
`define CR_ID_W 6

// SR mode bit, set means supervisor
`define CR_SR_MD 30

// SR block bit
// set on trap entry so nested interrupts stay masked
`define CR_SR_BL 28

// SR after reset
// only MD is set, core starts in supervisor mode
`define CR_SR_RESET 64'h0000_0000_4000_0000

`endif
